//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module nes_bus_tb -f all.f -Mdir obj_dir

run: compile
	./obj_dir/Vnes_bus_tb | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+tb
rtl/nes_bus_pkg.sv
rtl/clock_divider.sv
rtl/sprite_dmc_dma.sv
rtl/bus_arbiter.sv
rtl/nes_bus_core.sv
tb/nes_bus_tb.sv

//--- rtl/bus_arbiter.sv
// NES bus merge, decode and CPU read mux; PPU and APU reads come in as plain inputs and memory is qualified by cart_slot only
`timescale 1ns/100ps

module bus_arbiter import nes_bus_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  addr_t                   cpu_addr,
	input  data_t                   cpu_dout,
	input  logic                    cpu_rnw,
	input  addr_t                   dma_addr,
	input  data_t                   dma_dout,
	input  logic                    dma_active,
	input  logic                    dma_read,
	input  logic                    cart_slot,
	input  data_t                   mem_din,
	input  data_t                   ppu_din,
	input  data_t                   apu_status,
	input  logic [JOY_BITS-1:0]     joypad1_data,
	input  logic [JOY_BITS-1:0]     joypad2_data,
	output addr_t                   bus_addr,
	output data_t                   bus_dout,
	output logic                    bus_read,
	output logic                    bus_write,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    sprite_trigger,
	output data_t                   cpu_din,
	output logic [JOY_OUT_BITS-1:0] joypad_out,
	output logic [1:0]              joypad_clock
);

	logic  ppu_cs;   // 0x2000 to 0x3FFF
	logic  apu_cs;   // 0x4000 to 0x4017
	logic  joy1_cs;
	logic  joy2_cs;
	data_t open_bus;   // Last value seen by the CPU
	logic [JOY_OUT_BITS-1:0] joy_latch;

	// DMA takes the bus whole while it is active
	assign bus_addr  = dma_active ? dma_addr : cpu_addr;
	assign bus_dout  = dma_active ? dma_dout : cpu_dout;
	assign bus_read  = dma_active ? dma_read : cpu_rnw;
	assign bus_write = dma_active ? !dma_read : !cpu_rnw;

	assign ppu_cs  = (bus_addr >= PPU_LO) && (bus_addr < PPU_HI);
	assign apu_cs  = (bus_addr >= APU_LO) && (bus_addr < APU_HI);
	assign joy1_cs = (bus_addr == JOY1_ADDR);
	assign joy2_cs = (bus_addr == JOY2_ADDR);

	// Memory only during the cart slot and outside the register windows
	assign mem_read  = bus_read && cart_slot && !ppu_cs && !apu_cs;
	assign mem_write = bus_write && cart_slot && !ppu_cs && !apu_cs;

	assign sprite_trigger = bus_write && (bus_addr == OAM_DMA_ADDR);

	// Joypad clocks last as long as the read address is held
	assign joypad_clock = {joy2_cs && bus_read, joy1_cs && bus_read};
	assign joypad_out   = joy_latch;

	always_ff @(posedge clk) begin
		if (reset)
			joy_latch <= '0;
		else if (joy1_cs && bus_write)
			joy_latch <= bus_dout[JOY_OUT_BITS-1:0];   // Bit 0 strobes both pads
	end

	always_ff @(posedge clk) begin
		open_bus <= cpu_din;   // Floating lines keep the last driven value
	end

	always_comb begin
		if (reset)
			cpu_din = '0;
		else if (apu_cs) begin
			if (joy1_cs)
				cpu_din = {open_bus[$bits(data_t)-1:JOY_BITS], joypad1_data};
			else if (joy2_cs)
				cpu_din = {open_bus[$bits(data_t)-1:JOY_BITS], joypad2_data};
			else if (bus_addr == APU_STATUS_ADDR)
				cpu_din = apu_status;
			else
				cpu_din = open_bus;   // Write only registers
		end else if (ppu_cs)
			cpu_din = ppu_din;
		else
			cpu_din = mem_din;
	end

endmodule

//--- rtl/clock_divider.sv
// NTSC only clock enables; CPU_DIV must be a multiple of PPU_DIV and at least twice it, and the PPU tick counter is two bits
`timescale 1ns/100ps

module clock_divider #(
	parameter int CPU_DIV = 12,   // Master clocks per CPU cycle
	parameter int PPU_DIV = 4     // Master clocks per PPU dot
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,      // One clock wide, once per CPU cycle
	output logic ppu_ce,      // One clock wide, once per PPU dot
	output logic cart_ce,     // First PPU dot after a CPU tick
	output logic cart_slot,   // Level, memory access window
	output logic odd_cycle    // 1 = odd, 0 = even APU cycle
);

	localparam int CPU_W = $clog2(CPU_DIV + 1);
	localparam int PPU_W = $clog2(PPU_DIV + 1);

	logic [CPU_W-1:0] div_cpu;    // Counts 1 up to CPU_DIV
	logic [PPU_W-1:0] div_ppu;    // Counts 1 up to PPU_DIV
	logic [1:0]       ppu_tick;   // PPU dots since last CPU tick

	assign cpu_ce    = (div_cpu == CPU_W'(CPU_DIV));
	assign ppu_ce    = (div_ppu == PPU_W'(PPU_DIV));
	assign cart_slot = (ppu_tick == 2'd0);
	assign cart_ce   = cart_slot & ppu_ce;   // Cart sees the CPU data from here on

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu   <= CPU_W'(1);
			div_ppu   <= PPU_W'(1);
			ppu_tick  <= 2'd1;   // No cart slot before the first CPU tick
			odd_cycle <= 1'b1;
		end else begin
			div_cpu <= cpu_ce ? CPU_W'(1) : div_cpu + 1'b1;
			div_ppu <= ppu_ce ? PPU_W'(1) : div_ppu + 1'b1;

			// Both enables share an edge so the slot opens one dot later
			if (cpu_ce)
				ppu_tick <= 2'd0;
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 1'b1;

			if (cpu_ce)
				odd_cycle <= ~odd_cycle;   // Flips every CPU cycle
		end
	end

endmodule

//--- rtl/nes_bus_core.sv
// NES system bus top around an external 6502, NTSC timing only; the CPU must honour pause_cpu as its ready line
`timescale 1ns/100ps

module nes_bus_core import nes_bus_pkg::*; #(
	parameter int CPU_DIV = 12,   // Master clocks per CPU cycle
	parameter int PPU_DIV = 4     // Master clocks per PPU dot
) (
	input  logic                    clk,
	input  logic                    reset,
	input  addr_t                   cpu_addr,
	input  data_t                   cpu_dout,
	input  logic                    cpu_rnw,        // 1 = read
	input  logic                    dmc_request,
	input  addr_t                   dmc_addr,
	input  data_t                   mem_din,
	input  data_t                   ppu_din,
	input  data_t                   apu_status,
	input  logic [JOY_BITS-1:0]     joypad1_data,
	input  logic [JOY_BITS-1:0]     joypad2_data,
	output addr_t                   bus_addr,
	output data_t                   bus_dout,
	output logic                    bus_read,
	output logic                    bus_write,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    sprite_trigger,
	output data_t                   cpu_din,
	output logic [JOY_OUT_BITS-1:0] joypad_out,
	output logic [1:0]              joypad_clock,
	output logic                    cpu_ce,
	output logic                    ppu_ce,
	output logic                    cart_ce,
	output logic                    odd_cycle,
	output logic                    dmc_ack,
	output logic                    pause_cpu
);

	logic  cart_slot;
	addr_t dma_addr;
	data_t dma_dout;
	logic  dma_active;
	logic  dma_read;

	clock_divider #(
		.CPU_DIV (CPU_DIV),
		.PPU_DIV (PPU_DIV)
	) i_clock_divider (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.cart_ce   (cart_ce),
		.cart_slot (cart_slot),
		.odd_cycle (odd_cycle)
	);

	sprite_dmc_dma i_sprite_dmc_dma (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.dmc_request    (dmc_request),
		.cpu_read       (cpu_rnw),
		.cpu_dout       (cpu_dout),
		.bus_din        (cpu_din),   // Same byte the CPU would see
		.dmc_addr       (dmc_addr),
		.dma_addr       (dma_addr),
		.dma_active     (dma_active),
		.dma_read       (dma_read),
		.dma_dout       (dma_dout),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	bus_arbiter i_bus_arbiter (
		.clk            (clk),
		.reset          (reset),
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.cpu_rnw        (cpu_rnw),
		.dma_addr       (dma_addr),
		.dma_dout       (dma_dout),
		.dma_active     (dma_active),
		.dma_read       (dma_read),
		.cart_slot      (cart_slot),
		.mem_din        (mem_din),
		.ppu_din        (ppu_din),
		.apu_status     (apu_status),
		.joypad1_data   (joypad1_data),
		.joypad2_data   (joypad2_data),
		.bus_addr       (bus_addr),
		.bus_dout       (bus_dout),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.sprite_trigger (sprite_trigger),
		.cpu_din        (cpu_din),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

endmodule

//--- rtl/nes_bus_pkg.sv
// Shared bus types and address map for the NES system bus, which assumes the NTSC memory map and a 16-bit CPU bus
package nes_bus_pkg;

	// CPU side bus
	typedef logic [15:0] addr_t;   // Address seen by cart, PPU and APU
	typedef logic [7:0]  data_t;   // One byte of data

	// Single register addresses
	localparam addr_t OAM_DMA_ADDR    = 16'h4014;   // Write starts sprite DMA
	localparam addr_t OAM_DATA_ADDR   = 16'h2004;   // Sprite DMA writes land here
	localparam addr_t APU_STATUS_ADDR = 16'h4015;   // Only readable APU register
	localparam addr_t JOY1_ADDR       = 16'h4016;   // Strobe on write, port 1 on read
	localparam addr_t JOY2_ADDR       = 16'h4017;   // Port 2 on read

	// PPU registers and their mirrors
	localparam addr_t PPU_LO = 16'h2000;
	localparam addr_t PPU_HI = 16'h4000;   // Exclusive

	// APU and IO registers
	localparam addr_t APU_LO = 16'h4000;
	localparam addr_t APU_HI = 16'h4018;   // Exclusive

	// Controller ports
	localparam int JOY_BITS     = 5;   // Data lines per port
	localparam int JOY_OUT_BITS = 3;   // Strobe latch, bit 0 is the strobe itself

endpackage

//--- rtl/sprite_dmc_dma.sv
// Sprite and DMC DMA for the NES bus; steps only on cpu_ce, has no back-pressure, and stalls the CPU through pause_cpu alone
`timescale 1ns/100ps

module sprite_dmc_dma import nes_bus_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  cpu_ce,
	input  logic  odd_cycle,        // 1 on odd APU cycles
	input  logic  sprite_trigger,   // CPU writes the page register
	input  logic  dmc_request,      // Level from the APU, dropped after ack
	input  logic  cpu_read,         // CPU is in a read cycle
	input  data_t cpu_dout,         // Page number on the trigger write
	input  data_t bus_din,          // Read data back from the bus
	input  addr_t dmc_addr,         // Sample byte address
	output addr_t dma_addr,
	output logic  dma_active,       // DMA owns the bus
	output logic  dma_read,         // 1 = read, 0 = write
	output data_t dma_dout,         // Byte for the OAM write
	output logic  dmc_ack,
	output logic  pause_cpu
);

	// Bit 0 marks the CPU as held, bit 1 marks the copy running
	localparam logic [1:0] SPR_IDLE = 2'b00;
	localparam logic [1:0] SPR_WAIT = 2'b01;
	localparam logic [1:0] SPR_COPY = 2'b11;

	logic       dmc_state;     // DMC fetch pending
	logic [1:0] spr_state;
	data_t      page;          // High byte of the source
	logic [7:0] offset;        // Low byte of the source
	logic [8:0] next_offset;   // Carry marks the last pair
	data_t      last_val;      // Byte held for the write half

	assign next_offset = {1'b0, offset} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= SPR_IDLE;
			offset    <= 8'd0;
		end else if (cpu_ce) begin
			// DMC is noticed on an even read cycle, served on the next even one
			if (!dmc_state && dmc_request && cpu_read && !odd_cycle)
				dmc_state <= 1'b1;
			if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;

			if (sprite_trigger) begin
				offset    <= 8'd0;
				spr_state <= SPR_WAIT;
			end
			// Start once the CPU sits in a read on an odd cycle
			if (spr_state == SPR_WAIT && cpu_read && odd_cycle)
				spr_state <= SPR_COPY;
			if (spr_state[1] && !odd_cycle && dmc_state)
				spr_state <= SPR_WAIT;   // DMC stole the read, redo the pair
			if (spr_state[1] && odd_cycle)
				offset <= next_offset[7:0];
			if (spr_state[1] && odd_cycle && next_offset[8])
				spr_state <= SPR_IDLE;   // 256 pairs done
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				page <= cpu_dout;
			if (spr_state[1] && !odd_cycle)
				last_val <= bus_din;   // Captured at the end of the read half
		end
	end

	assign dmc_ack    = dmc_state && !odd_cycle;
	assign pause_cpu  = spr_state[0] || dmc_request;
	assign dma_active = dmc_ack || spr_state[1];
	assign dma_read   = !odd_cycle;   // Reads even, writes odd
	assign dma_dout   = last_val;

	always_comb begin
		if (dmc_ack)
			dma_addr = dmc_addr;
		else if (!odd_cycle)
			dma_addr = {page, offset};
		else
			dma_addr = OAM_DATA_ADDR;
	end

endmodule

//--- tb/nes_bus_model.svh
// Reference model for the NES bus tests; memory is a pure hash of the address and needs CPU_DIV and PPU_DIV in scope
`ifndef NES_BUS_MODEL_SVH
`define NES_BUS_MODEL_SVH

// Both address bytes folded together, so every address bit shows up in the data
function automatic logic [7:0] mem_byte(input logic [15:0] addr);
	return addr[7:0] ^ addr[15:8];
endfunction

// Anything below the PPU registers or above the APU and IO block
function automatic logic in_mem_window(input logic [15:0] addr);
	return (addr < 16'h2000) || (addr >= 16'h4018);
endfunction

// Byte the CPU sees for an address, given the open bus and the register inputs
function automatic logic [7:0] expected_din(input logic [15:0] addr, input logic [7:0] open_bus,
		input logic [7:0] ppu, input logic [7:0] apu, input logic [4:0] joy1, input logic [4:0] joy2);
	if (addr >= 16'h2000 && addr < 16'h4000)
		return ppu;                      // All PPU mirrors
	if (addr == 16'h4015)
		return apu;
	if (addr == 16'h4016)
		return {open_bus[7:5], joy1};    // Top bits float
	if (addr == 16'h4017)
		return {open_bus[7:5], joy2};
	if (addr >= 16'h4000 && addr < 16'h4018)
		return open_bus;                 // Write only registers
	return mem_byte(addr);
endfunction

// {cpu_ce, ppu_ce, cart_ce, odd_cycle} on the n-th clock after reset, counted from 1
function automatic logic [3:0] expected_enables(input int n);
	logic cpu;
	logic ppu;
	logic cart;
	logic odd;
	cpu  = (n % CPU_DIV) == 0;
	ppu  = (n % PPU_DIV) == 0;
	cart = (n > CPU_DIV) && ((n % CPU_DIV) == PPU_DIV);   // One dot after each CPU tick
	odd  = (((n - 1) / CPU_DIV) % 2) == 0;                 // Starts odd, flips after each tick
	return {cpu, ppu, cart, odd};
endfunction

`endif

//--- tb/nes_bus_tb.sv
// NES bus core testbench; the CPU is one held bus cycle per cpu_ce, memory a fixed address hash
`timescale 1ns/100ps

module nes_bus_tb;

	localparam int CPU_DIV = 12;
	localparam int PPU_DIV = 4;
	localparam int N_READS = 200;
	localparam int N_DMC   = 4;
	// Twice the reads, one sprite copy with slack, and the DMC and joypad cycles
	localparam int WATCHDOG_NS = 2 * (N_READS + 2 * 256 + 16 * N_DMC + 100) * CPU_DIV * 20;

	logic        clk, reset, cpu_rnw, dmc_request;
	logic [15:0] cpu_addr, dmc_addr, bus_addr;
	logic [7:0]  cpu_dout, mem_din, ppu_din, apu_status, bus_dout, cpu_din;
	logic [4:0]  joypad1_data, joypad2_data;
	logic [2:0]  joypad_out;
	logic [1:0]  joypad_clock;
	logic        bus_read, bus_write, mem_read, mem_write, sprite_trigger;
	logic        cpu_ce, ppu_ce, cart_ce, odd_cycle, dmc_ack, pause_cpu;

	int          seed = 32'hf734_c02e;
	int          err_ce, err_rd, err_spr, err_dmc, err_seq;   // One count per checker
	int          n_clk, mem_pulses, exp_mem_pulses, mem_writes, exp_mem_writes;
	int          spr_reads, spr_writes, acks;
	logic        rd_check, spr_check, spr_pending, exp_trigger;
	logic [7:0]  exp_din, last_din, spr_page;
	logic [1:0]  exp_joy_clk;
	logic [15:0] spr_last;                                    // Source of the pending OAM byte

	`include "nes_bus_model.svh"

	assign mem_din = mem_byte(bus_addr);   // Zero wait state memory

	nes_bus_core #(.CPU_DIV(CPU_DIV), .PPU_DIV(PPU_DIV)) i_nes_bus_core (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the test sequence never finished", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	// Enable cadence checked on every clock from reset release to the end
	always @(negedge clk) begin
		if (!reset) begin
			n_clk = n_clk + 1;
			if ({cpu_ce, ppu_ce, cart_ce, odd_cycle} !== expected_enables(n_clk)) begin
				err_ce++;
				$display("Error: {cpu_ce,ppu_ce,cart_ce,odd_cycle} = %h, expected %h at clock %0d",
					{cpu_ce, ppu_ce, cart_ce, odd_cycle}, expected_enables(n_clk), n_clk);
			end
		end
	end

	// CPU cycle checker with strobes on every clock and read data at the end of the cycle
	always @(negedge clk) begin
		if (rd_check) begin
			if (mem_read)
				mem_pulses++;
			if (mem_write)
				mem_writes++;
			if (joypad_clock !== exp_joy_clk) begin
				err_rd++;
				$display("Error: joypad_clock = %h, expected %h", joypad_clock, exp_joy_clk);
			end
			if (sprite_trigger !== exp_trigger) begin
				err_rd++;
				$display("Error: sprite_trigger = %h, expected %h at %h", sprite_trigger,
					exp_trigger, bus_addr);
			end
			if (cpu_ce && cpu_din !== exp_din) begin
				err_rd++;
				$display("Error: cpu_din = %h, expected %h at %h", cpu_din, exp_din, bus_addr);
			end
			if (cpu_ce && mem_pulses != exp_mem_pulses) begin
				err_rd++;
				$display("Error: mem_read high for %h clocks at %h, expected %h", mem_pulses,
					bus_addr, exp_mem_pulses);
			end
			if (cpu_ce && mem_writes != exp_mem_writes) begin
				err_rd++;
				$display("Error: mem_write high for %h clocks at %h, expected %h", mem_writes,
					bus_addr, exp_mem_writes);
			end
		end
		if (cpu_ce) begin
			mem_pulses = 0;   // Count restarts with each CPU cycle
			mem_writes = 0;
		end
	end

	// Sprite copy sampled once per CPU cycle
	always @(negedge clk) begin
		if (spr_check && cpu_ce) begin
			if (bus_read && bus_addr[15:8] == spr_page) begin
				if (bus_addr[7:0] !== 8'(spr_reads)) begin
					err_spr++;
					$display("Error: bus_addr = %h, expected %h", bus_addr, {spr_page, 8'(spr_reads)});
				end
				if (spr_pending) begin
					err_spr++;
					$display("Two sprite reads came without an OAM write between them");
				end
				spr_last    = bus_addr;
				spr_pending = 1'b1;
				spr_reads++;
			end else if (bus_write) begin
				if (bus_addr !== 16'h2004) begin
					err_spr++;
					$display("Error: bus_addr = %h, expected %h", bus_addr, 16'h2004);
				end
				if (!spr_pending) begin
					err_spr++;
					$display("A sprite write came without a read before it");
				end else if (bus_dout !== mem_byte(spr_last)) begin
					err_spr++;
					$display("Error: bus_dout = %h, expected %h", bus_dout, mem_byte(spr_last));
				end
				spr_pending = 1'b0;
				spr_writes++;
			end
		end
	end

	// DMC fetch cycles
	always @(negedge clk) begin
		if (cpu_ce && dmc_ack) begin
			acks++;
			if (odd_cycle) begin
				err_dmc++;
				$display("dmc_ack was high on an odd CPU cycle");
			end
			if (bus_addr !== dmc_addr) begin
				err_dmc++;
				$display("Error: bus_addr = %h, expected %h", bus_addr, dmc_addr);
			end
			if (!bus_read) begin
				err_dmc++;
				$display("bus_read was low during a DMC fetch");
			end
		end
	end

	// Lands just after the edge that starts a CPU cycle
	task automatic next_cpu_cycle;
		do
			@(negedge clk);
		while (!cpu_ce);
		@(posedge clk);
		#2;
	endtask

	// One CPU cycle with fresh register inputs and the expectations for it
	task automatic cpu_cycle(input logic [15:0] addr, input logic rnw, input logic [7:0] data);
		next_cpu_cycle();
		cpu_addr     = addr;
		cpu_rnw      = rnw;
		cpu_dout     = data;
		ppu_din      = 8'($random(seed));
		apu_status   = 8'($random(seed));
		joypad1_data = 5'($random(seed));
		joypad2_data = 5'($random(seed));
		exp_din = expected_din(addr, last_din, ppu_din, apu_status, joypad1_data, joypad2_data);
		last_din       = exp_din;   // Open bus for the next cycle
		exp_joy_clk    = rnw ? {addr == 16'h4017, addr == 16'h4016} : 2'b00;
		exp_trigger    = !rnw && (addr == 16'h4014);
		exp_mem_pulses = (rnw && in_mem_window(addr)) ? PPU_DIV : 0;
		exp_mem_writes = (!rnw && in_mem_window(addr)) ? PPU_DIV : 0;
		rd_check       = 1'b1;
	endtask

	task automatic random_read;
		logic [15:0] r;
		logic [15:0] addr;
		r = 16'($random(seed));
		case (2'($random(seed)))
			2'd0: addr = r;                               // Anywhere
			2'd1: addr = {3'b001, r[12:0]};               // PPU registers and mirrors
			2'd2: addr = {8'h40, r[7:0] % 8'd24};         // APU and IO block
			default: addr = 16'h4015 + {14'd0, r[1:0] % 2'd3};
		endcase
		cpu_cycle(addr, 1'b1, 8'h00);
	endtask

	initial begin
		logic [7:0] data;
		int cycles;
		reset = 1'b1;
		{cpu_addr, cpu_dout, cpu_rnw} = {16'h0000, 8'h00, 1'b1};
		{dmc_request, dmc_addr, ppu_din, apu_status} = '0;
		{joypad1_data, joypad2_data} = '0;
		{rd_check, spr_check, spr_pending, exp_trigger, exp_din, last_din, exp_joy_clk} = '0;
		spr_page = 8'h00;
		spr_last = 16'h0000;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		repeat (N_READS) random_read();

		for (int i = 0; i < 6; i++) begin
			data = 8'($random(seed));
			cpu_cycle({3'b000, 13'($random(seed))}, 1'b0, data);   // Work RAM write
			cpu_cycle(16'h4016, 1'b0, data);    // Strobe latch write
			cpu_cycle(16'h4016, 1'b1, 8'h00);
			if (joypad_out !== data[2:0]) begin
				err_seq++;
				$display("Error: joypad_out = %h, expected %h", joypad_out, data[2:0]);
			end
			cpu_cycle(16'h4017, 1'b1, 8'h00);
		end

		spr_page = {3'b000, 5'($random(seed))};   // Always inside work RAM
		cpu_cycle(16'h4014, 1'b0, spr_page);
		next_cpu_cycle();
		rd_check = 1'b0;
		if (!pause_cpu) begin
			err_seq++;
			$display("pause_cpu did not rise after the write to 0x4014");
		end
		spr_check = 1'b1;
		cpu_addr  = 16'h2002;   // Stalled CPU polls PPU status
		cpu_rnw   = 1'b1;
		cycles    = 0;
		while (pause_cpu && cycles < 2 * 256 + 16) begin
			next_cpu_cycle();
			cycles++;
		end
		spr_check = 1'b0;
		if (pause_cpu || spr_reads != 256 || spr_writes != 256) begin
			err_seq++;
			$display("Sprite DMA ended with %0d reads and %0d writes, pause_cpu %b", spr_reads,
				spr_writes, pause_cpu);
		end

		cpu_addr = 16'h8000;
		for (int i = 0; i < N_DMC; i++) begin
			next_cpu_cycle();
			dmc_addr    = {1'b1, 15'($random(seed))};   // Samples sit in 0x8000 to 0xFFFF
			dmc_request = 1'b1;
			@(negedge clk);
			if (!pause_cpu) begin
				err_seq++;
				$display("pause_cpu did not follow dmc_request");
			end
			cycles = 0;
			while (!dmc_ack && cycles < 16 * CPU_DIV) begin
				@(negedge clk);
				cycles++;
			end
			if (!dmc_ack) begin
				err_seq++;
				$display("No dmc_ack within 16 CPU cycles of the request");
			end
			next_cpu_cycle();   // Drop right after the fetch cycle
			dmc_request = 1'b0;
			repeat (2) next_cpu_cycle();
			if (pause_cpu) begin
				err_seq++;
				$display("pause_cpu stayed high after dmc_request dropped");
			end
		end
		if (acks != N_DMC) begin
			err_seq++;
			$display("Error: dmc_ack count = %h, expected %h", acks, N_DMC);
		end

		$display("Errors: enables %0d, reads %0d, sprite DMA %0d, DMC %0d, sequence %0d",
			err_ce, err_rd, err_spr, err_dmc, err_seq);
		if (err_ce + err_rd + err_spr + err_dmc + err_seq == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
